//--- Bender.yml
package:
  name: regfile

export_include_dirs:
  - src

sources:
  - src/regfile_pkg.sv
  - src/regfile_port_pkg.sv
  - src/regfile_write_merge.sv
  - src/regfile_bank.sv
  - src/regfile_bypass.sv
  - src/regfile_top.sv
  - target: simulation
    files:
      - dv/regfile_tb.sv

//--- dv/regfile_tb.sv
`timescale 1ns/1ns

`include "regfile_params.svh"

module regfile_tb
	import regfile_pkg::*;
	import regfile_port_pkg::*;
();

	localparam int LANE_W = `RF_DATA_W / `RF_BYTES;
	localparam int RAND_CYCLES = 4000;

	logic      clka;
	logic      rst_n;
	wr_req_t   wr0;
	wr_req_t   wr1;
	reg_addr_t rd_addr [`RF_READ_PORTS];
	reg_data_t rd_data [`RF_READ_PORTS];

	// reference state after every write driven so far
	reg_data_t model [`RF_DEPTH];

	// read addresses for the next cycle, and the ones currently on the DUT pins
	reg_addr_t nxt_addr [`RF_READ_PORTS];
	reg_addr_t cur_addr [`RF_READ_PORTS];

	// value each read port must show in the cycle that follows the last edge
	reg_data_t exp_data [`RF_READ_PORTS];
	logic      chk_on;

	int        zero_ctx [3] = '{0, 42, 127};
	reg_addr_t addr_a;
	reg_addr_t addr_b;
	reg_addr_t addr_c;
	reg_addr_t addr_z;

	regfile_top u_regfile_top (
		.clka    (clka),
		.rst_n   (rst_n),
		.wr0     (wr0),
		.wr1     (wr1),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	always #50 clka = ~clka;

	// ===========================================================================
	// helpers
	// ===========================================================================

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	function automatic reg_addr_t make_addr(input int ctx, input int idx);
		return reg_addr_t'(ctx << `RF_REG_W) | reg_addr_t'(idx);
	endfunction

	function automatic wr_req_t wreq(input reg_addr_t a, input byte_en_t be, input reg_data_t d);
		wr_req_t w;
		w.en = 1'b1;
		w.be = be;
		w.addr = a;
		w.data = d;
		return w;
	endfunction

	// few contexts and registers, so port collisions and bypass hits are common
	function automatic wr_req_t rand_write();
		wr_req_t w;
		w.en = ($urandom_range(0, 3) != 0);
		w.be = byte_en_t'($urandom);
		w.addr = make_addr($urandom_range(0, 2), $urandom_range(0, 5));
		w.data = {$urandom, $urandom};
		return w;
	endfunction

	// enabled bytes overwrite the model, so the later call wins on shared bytes
	function automatic void apply_write(input wr_req_t w);
		if (w.en) begin
			for (int b = 0; b < `RF_BYTES; b++) begin
				if (w.be[b]) begin
					model[w.addr][b*LANE_W +: LANE_W] = w.data[b*LANE_W +: LANE_W];
				end
			end
		end
	endfunction

	// register field 0 reads zero in any context
	function automatic reg_data_t expect_read(input reg_addr_t a);
		if (a[`RF_REG_W-1:0] == '0) begin
			return '0;
		end
		return model[a];
	endfunction

	function automatic bit outputs_known();
		for (int p = 0; p < `RF_READ_PORTS; p++) begin
			if ($isunknown(rd_data[p])) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	task automatic set_all_reads(input reg_addr_t a);
		for (int p = 0; p < `RF_READ_PORTS; p++) begin
			nxt_addr[p] = a;
		end
	endtask

	// one clock cycle: drive the new requests and work out what the read ports
	// must show during the cycle that starts at this edge
	task automatic step(input wr_req_t w0, input wr_req_t w1);
		reg_addr_t cap [`RF_READ_PORTS];
		@(posedge clka);
		for (int p = 0; p < `RF_READ_PORTS; p++) begin
			cap[p] = rst_n ? cur_addr[p] : '0;
		end
		apply_write(w0);
		apply_write(w1);
		wr0 <= w0;
		wr1 <= w1;
		for (int p = 0; p < `RF_READ_PORTS; p++) begin
			rd_addr[p] <= nxt_addr[p];
			cur_addr[p] = nxt_addr[p];
			exp_data[p] <= expect_read(cap[p]);
		end
		chk_on <= 1'b1;
	endtask

	// ===========================================================================
	// checking
	// ===========================================================================

	for (genvar p = 0; p < `RF_READ_PORTS; p++) begin : g_chk
		a_rd_data: assert property (@(posedge clka) chk_on |-> rd_data[p] === exp_data[p])
		else
			abort_run($sformatf("ERR %0t: read port %0d returned %h, expected %h", $time, p,
				$sampled(rd_data[p]), $sampled(exp_data[p])));
	end

	// ===========================================================================
	// stimulus
	// ===========================================================================

	initial begin
		int n;
		void'($urandom(31953));
		clka = 1'b0;
		rst_n = 1'b0;
		wr0 = '0;
		wr1 = '0;
		chk_on = 1'b0;
		for (int p = 0; p < `RF_READ_PORTS; p++) begin
			rd_addr[p] = '0;
			nxt_addr[p] = '0;
			cur_addr[p] = '0;
			exp_data[p] = '0;
		end

		// a real register on the read ports must still read zero while in reset
		set_all_reads(make_addr(5, 7));
		for (int i = 0; i < 15; i++) begin
			step('0, '0);
		end

		// register zero is captured at the first edge after release
		set_all_reads('0);
		step('0, '0);
		rst_n <= 1'b1;

		n = 0;
		while (!outputs_known()) begin
			if (n == 8) begin
				abort_run("read ports still unknown 8 cycles after reset release");
			end
			step('0, '0);
			n++;
		end

		// full write, then a partial overwrite, then a later read
		addr_a = make_addr(3, 5);
		step(wreq(addr_a, 8'hff, 64'h0123_4567_89ab_cdef), '0);
		step('0, '0);
		step('0, wreq(addr_a, 8'h0f, 64'hdead_beef_cafe_f00d));
		set_all_reads(addr_a);
		step('0, '0);
		step('0, '0);

		// all six ports read a register that is written in the read cycle
		addr_b = make_addr(9, 17);
		step(wreq(addr_b, 8'hff, 64'h1111_2222_3333_4444), '0);
		set_all_reads(addr_b);
		step('0, '0);
		step(wreq(addr_b, 8'h33, 64'haaaa_bbbb_cccc_dddd),
			wreq(addr_b, 8'hc0, 64'h5a5a_0000_0000_0000));
		step('0, '0);

		// both ports hit the same bytes, first through the bypass, then from storage
		addr_c = make_addr(64, 2);
		step(wreq(addr_c, 8'hff, 64'h0f0f_0f0f_0f0f_0f0f), '0);
		set_all_reads(addr_c);
		step('0, '0);
		step(wreq(addr_c, 8'hff, 64'h7777_7777_7777_7777),
			wreq(addr_c, 8'h3c, 64'h9999_9999_9999_9999));
		step('0, '0);
		step('0, '0);

		foreach (zero_ctx[i]) begin
			addr_z = make_addr(zero_ctx[i], 0);
			set_all_reads(addr_z);
			step(wreq(addr_z, 8'hff, '1), '0);
			step(wreq(addr_z, 8'hff, '1), wreq(addr_z, 8'h0f, 64'h1234_5678_9abc_def0));
			step('0, '0);
		end

		for (int i = 0; i < RAND_CYCLES; i++) begin
			for (int p = 0; p < `RF_READ_PORTS; p++) begin
				nxt_addr[p] = make_addr($urandom_range(0, 2), $urandom_range(0, 5));
			end
			step(rand_write(), rand_write());
		end

		// let the last expected values reach their check
		step('0, '0);
		step('0, '0);
		#1;
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- sim.f
+incdir+src
src/regfile_pkg.sv
src/regfile_port_pkg.sv
src/regfile_write_merge.sv
src/regfile_bank.sv
src/regfile_bypass.sv
src/regfile_top.sv
dv/regfile_tb.sv

//--- src/regfile_bank.sv
`timescale 1ns/1ns

`include "regfile_params.svh"

module regfile_bank
	import regfile_pkg::*;
	import regfile_port_pkg::*;
(
	input  logic      clka,
	input  logic      rst_n,
	input  wr_req_t   wm0,
	input  wr_req_t   wm1,
	input  reg_addr_t rd_addr [`RF_READ_PORTS],
	output reg_addr_t raddr_q [`RF_READ_PORTS],
	output reg_data_t raw_data [`RF_READ_PORTS]
);

	localparam int LANE_W = `RF_DATA_W / `RF_BYTES;

	// one entry per context and architectural register
	reg_data_t mem [`RF_DEPTH];

	// ===========================================================================
	// storage write, both ports at the same edge
	// ===========================================================================

	// the merge stage has already made the two byte masks disjoint
	always_ff @(posedge clka) begin
		for (int b = 0; b < `RF_BYTES; b++) begin
			if (wm0.en && wm0.be[b]) begin
				mem[wm0.addr][b*LANE_W +: LANE_W] <= wm0.data[b*LANE_W +: LANE_W];
			end
			if (wm1.en && wm1.be[b]) begin
				mem[wm1.addr][b*LANE_W +: LANE_W] <= wm1.data[b*LANE_W +: LANE_W];
			end
		end
	end

	// ===========================================================================
	// read address capture and array read
	// ===========================================================================

	for (genvar p = 0; p < `RF_READ_PORTS; p++) begin : g_rd
		// a cleared address points at register zero, which reads as zero
		always_ff @(posedge clka or negedge rst_n) begin
			if (!rst_n) begin
				raddr_q[p] <= '0;
			end else begin
				raddr_q[p] <= rd_addr[p];
			end
		end

		assign raw_data[p] = mem[raddr_q[p]];
	end

	// an unknown write address would corrupt an arbitrary entry
	a_wm0_addr_known: assert property (@(posedge clka) disable iff (!rst_n)
		wm0.en |-> !$isunknown(wm0.addr));
	a_wm1_addr_known: assert property (@(posedge clka) disable iff (!rst_n)
		wm1.en |-> !$isunknown(wm1.addr));

endmodule

//--- src/regfile_bypass.sv
`timescale 1ns/1ns

`include "regfile_params.svh"

module regfile_bypass
	import regfile_pkg::*;
	import regfile_port_pkg::*;
(
	input  reg_addr_t raddr_q,
	input  reg_data_t raw_data,
	input  wr_req_t   wm0,
	input  wr_req_t   wm1,
	output reg_data_t rd_data
);

	localparam int LANE_W = `RF_DATA_W / `RF_BYTES;

	reg_idx_t  reg_idx;
	byte_en_t  sel0;
	byte_en_t  sel1;
	reg_data_t merged;

	// ===========================================================================
	// forwarding of the writes of this cycle
	// ===========================================================================

	// the register field alone decides the zero rule, in every context
	assign reg_idx = raddr_q[`RF_REG_W-1:0];

	// lanes that each write port is putting into the register being read
	assign sel1 = (wm1.en && (wm1.addr == raddr_q)) ? wm1.be : '0;
	assign sel0 = (wm0.en && (wm0.addr == raddr_q)) ? wm0.be : '0;

	// port 1 is checked first, matching the order the storage resolves to;
	// after the merge the two masks never overlap anyway
	always_comb begin
		merged = raw_data;
		for (int b = 0; b < `RF_BYTES; b++) begin
			if (sel1[b]) begin
				merged[b*LANE_W +: LANE_W] = wm1.data[b*LANE_W +: LANE_W];
			end else if (sel0[b]) begin
				merged[b*LANE_W +: LANE_W] = wm0.data[b*LANE_W +: LANE_W];
			end
		end
	end

	// register zero is hardwired, whatever the array or a write holds
	assign rd_data = (reg_idx == '0) ? '0 : merged;

endmodule

//--- src/regfile_params.svh
`ifndef REGFILE_PARAMS_SVH
`define REGFILE_PARAMS_SVH

// ===========================================================================
// register file geometry
// ===========================================================================

// width of one integer register
`define RF_DATA_W 64

// full register address, context in the upper bits and register below
`define RF_ADDR_W 12

// architectural register field at the bottom of the address
`define RF_REG_W 5

// byte lanes per register, one write enable bit each
`define RF_BYTES 8

// every read port is served in parallel with its own bypass
`define RF_READ_PORTS 6

// one entry per context and register, so 2**RF_ADDR_W
`define RF_DEPTH 4096

`endif

//--- src/regfile_pkg.sv
`include "regfile_params.svh"

package regfile_pkg;

	// ===========================================================================
	// basic vector types of the register file
	// ===========================================================================

	// one register value as stored and as read
	typedef logic [`RF_DATA_W-1:0] reg_data_t;

	// upper 7 bits pick the context, lower 5 bits the architectural register
	typedef logic [`RF_ADDR_W-1:0] reg_addr_t;

	// architectural register index within a context
	typedef logic [`RF_REG_W-1:0] reg_idx_t;

	// one bit per byte lane of a register
	typedef logic [`RF_BYTES-1:0] byte_en_t;

endpackage

//--- src/regfile_port_pkg.sv
`include "regfile_params.svh"

package regfile_port_pkg;

	import regfile_pkg::*;

	// ===========================================================================
	// write port request
	// ===========================================================================

	// a write lands only when en is high, and only on bytes whose be bit is set
	typedef struct packed {
		logic      en;
		byte_en_t  be;
		reg_addr_t addr;
		reg_data_t data;
	} wr_req_t;

endpackage

//--- src/regfile_top.sv
`timescale 1ns/1ns

`include "regfile_params.svh"

module regfile_top
	import regfile_pkg::*;
	import regfile_port_pkg::*;
(
	input  logic      clka,
	input  logic      rst_n,
	input  wr_req_t   wr0,
	input  wr_req_t   wr1,
	input  reg_addr_t rd_addr [`RF_READ_PORTS],
	output reg_data_t rd_data [`RF_READ_PORTS]
);

	// merged write requests, shared by the bank and every bypass unit
	wr_req_t   wm0;
	wr_req_t   wm1;

	// per read port, captured address and the array value behind it
	reg_addr_t raddr_q [`RF_READ_PORTS];
	reg_data_t raw_data [`RF_READ_PORTS];

	// ===========================================================================
	// write side
	// ===========================================================================

	regfile_write_merge u_write_merge (
		.wr0 (wr0),
		.wr1 (wr1),
		.wm0 (wm0),
		.wm1 (wm1)
	);

	regfile_bank u_bank (
		.clka     (clka),
		.rst_n    (rst_n),
		.wm0      (wm0),
		.wm1      (wm1),
		.rd_addr  (rd_addr),
		.raddr_q  (raddr_q),
		.raw_data (raw_data)
	);

	// ===========================================================================
	// read side, one bypass per port
	// ===========================================================================

	for (genvar p = 0; p < `RF_READ_PORTS; p++) begin : g_port
		regfile_bypass u_bypass (
			.raddr_q  (raddr_q[p]),
			.raw_data (raw_data[p]),
			.wm0      (wm0),
			.wm1      (wm1),
			.rd_data  (rd_data[p])
		);
	end

endmodule

//--- src/regfile_write_merge.sv
`timescale 1ns/1ns

`include "regfile_params.svh"

module regfile_write_merge
	import regfile_pkg::*;
	import regfile_port_pkg::*;
(
	input  wr_req_t wr0,
	input  wr_req_t wr1,
	output wr_req_t wm0,
	output wr_req_t wm1
);

	// ===========================================================================
	// write port 1 priority
	// ===========================================================================

	logic     same_addr;
	byte_en_t overlap;

	// both ports aim at the same register in this cycle
	assign same_addr = wr0.en && wr1.en && (wr0.addr == wr1.addr);

	// bytes that port 1 claims away from port 0
	assign overlap = same_addr ? (wr0.be & wr1.be) : '0;

	// port 0 keeps its data and loses only the contested lanes, so the bank
	// and the bypass units never see two writers on one byte
	always_comb begin
		wm0 = wr0;
		wm0.be = wr0.be & ~overlap;
	end

	// port 1 goes through as it came in
	always_comb begin
		wm1 = wr1;
	end

endmodule
